/* hdl/isa_pkg.sv */
/*
 * Instruction set definitions for the integer execution cluster.
 * Holds the opcode and function codes of the supported Alpha integer subset
 * and the instruction-word union with its operate and memory views.
 */
`default_nettype none

package isa_pkg;

	// Major opcodes
	localparam logic [5:0] INTA_GRP = 6'h10;	// Integer arithmetic group
	localparam logic [5:0] INTL_GRP = 6'h11;	// Logical group
	localparam logic [5:0] INTS_GRP = 6'h12;	// Shift group
	localparam logic [5:0] LDA_INST = 6'h08;	// Memory format, address only

	// INTA function codes
	localparam logic [6:0] ADDQ   = 7'h20;
	localparam logic [6:0] SUBQ   = 7'h29;
	localparam logic [6:0] CMPEQ  = 7'h2d;
	localparam logic [6:0] CMPULT = 7'h1d;
	localparam logic [6:0] CMPULE = 7'h3d;
	localparam logic [6:0] CMPLT  = 7'h4d;
	localparam logic [6:0] CMPLE  = 7'h6d;

	// INTL function codes
	localparam logic [6:0] AND    = 7'h00;
	localparam logic [6:0] BIC    = 7'h08;
	localparam logic [6:0] BIS    = 7'h20;
	localparam logic [6:0] ORNOT  = 7'h28;
	localparam logic [6:0] XOR    = 7'h40;
	localparam logic [6:0] EQV    = 7'h48;

	// INTS function codes
	localparam logic [6:0] SRL    = 7'h34;
	localparam logic [6:0] SLL    = 7'h39;
	localparam logic [6:0] SRA    = 7'h3c;

	// Operate format. With is_lit set, rb and sbz together form the 8-bit literal
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [2:0] sbz;
		logic       is_lit;
		logic [6:0] func;
		logic [4:0] rc;
	} op_fmt_s;

	// Memory format
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [15:0] disp;
	} mem_fmt_s;

	// One instruction word, read through whichever format the opcode selects
	typedef union packed {
		op_fmt_s  op;
		mem_fmt_s mem;
	} alpha_inst_u;

endpackage

`default_nettype wire

/* hdl/core_pkg.sv */
/*
 * Out-of-order core widths and the packets that move through the
 * integer execution cluster: issue, per-unit result, CDB and
 * branch recovery.
 */
`default_nettype none

package core_pkg;

	localparam int PRF_IDX_W = 6;	// Physical register tag
	localparam int ROB_IDX_W = 5;	// ROB index, one extra wrap bit carried
	localparam int BR_MASK_W = 4;	// One bit per unresolved branch
	localparam int XLEN      = 64;

	// Issue source to ALU
	typedef struct packed {
		logic                    valid;
		logic [XLEN-1:0]         opa;
		logic [XLEN-1:0]         opb;
		isa_pkg::alpha_inst_u    inst;
		logic [PRF_IDX_W-1:0]    dest_tag;
		logic [ROB_IDX_W:0]      rob_idx;
		logic [BR_MASK_W-1:0]    br_mask;
	} issue_pkt_s;

	// ALU result stage and result queue entries
	typedef struct packed {
		logic                    valid;
		logic                    squashed;	// Killed by recovery, still owns a credit
		logic [XLEN-1:0]         result;
		logic [PRF_IDX_W-1:0]    dest_tag;
		logic [ROB_IDX_W:0]      rob_idx;
		logic [BR_MASK_W-1:0]    br_mask;
	} exec_pkt_s;

	// Common data bus beat
	typedef struct packed {
		logic                    valid;
		logic [XLEN-1:0]         result;
		logic [PRF_IDX_W-1:0]    dest_tag;
		logic [ROB_IDX_W:0]      rob_idx;
	} cdb_pkt_s;

	// Branch resolution from the ROB
	typedef struct packed {
		logic                    recovery;	// Mispredict, squash dependents
		logic                    pred_correct;	// Clear the resolved bit instead
		logic [BR_MASK_W-1:0]    tag_fix;
	} br_recov_s;

endpackage

`default_nettype wire

/* hdl/fu_alu.sv */
/*
 * Integer ALU functional unit. Selects operands from the instruction
 * format, computes one result of the integer subset and registers it in
 * a single stage. Branch masks are kept current against recovery.
 */
`timescale 1ns/1ns
`default_nettype none

module fu_alu (
	input  logic                 clk,
	input  logic                 rst,
	input  core_pkg::issue_pkt_s issue_i,
	input  core_pkg::br_recov_s  recov_i,
	output core_pkg::exec_pkt_s  exec_o
);

	logic                           is_mem;
	logic [core_pkg::XLEN-1:0]      lit_zext;
	logic [core_pkg::XLEN-1:0]      disp_sext;
	logic [core_pkg::XLEN-1:0]      opa_sel;
	logic [core_pkg::XLEN-1:0]      opb_sel;
	logic [core_pkg::XLEN-1:0]      result;
	logic                           enter_hit;
	logic [core_pkg::BR_MASK_W-1:0] enter_mask;
	logic                           held_hit;

	logic                           valid_q;
	logic                           squashed_q;
	logic [core_pkg::XLEN-1:0]      result_q;
	logic [core_pkg::PRF_IDX_W-1:0] dest_tag_q;
	logic [core_pkg::ROB_IDX_W:0]   rob_idx_q;
	logic [core_pkg::BR_MASK_W-1:0] br_mask_q;

	function automatic logic signed_lt(input logic [63:0] a, input logic [63:0] b);
		if (a[63] == b[63]) begin
			return a < b;	// Same sign, unsigned compare holds
		end
		return a[63];
	endfunction

	assign is_mem    = (issue_i.inst.op.opcode == isa_pkg::LDA_INST);
	assign lit_zext  = {{(core_pkg::XLEN-8){1'b0}}, issue_i.inst.op.rb, issue_i.inst.op.sbz};
	assign disp_sext = {{(core_pkg::XLEN-16){issue_i.inst.mem.disp[15]}}, issue_i.inst.mem.disp};

	// Memory format uses the displacement in place of opa
	assign opa_sel = is_mem ? disp_sext : issue_i.opa;
	assign opb_sel = (!is_mem && issue_i.inst.op.is_lit) ? lit_zext : issue_i.opb;

	always_comb begin
		result = '0;	// Unsupported encodings give zero
		case (issue_i.inst.op.opcode)
			isa_pkg::INTA_GRP: begin
				case (issue_i.inst.op.func)
					isa_pkg::ADDQ:   result = opa_sel + opb_sel;
					isa_pkg::SUBQ:   result = opa_sel - opb_sel;
					isa_pkg::CMPEQ:  result[0] = (opa_sel == opb_sel);
					isa_pkg::CMPULT: result[0] = (opa_sel < opb_sel);
					isa_pkg::CMPULE: result[0] = (opa_sel <= opb_sel);
					isa_pkg::CMPLT:  result[0] = signed_lt(opa_sel, opb_sel);
					isa_pkg::CMPLE:  result[0] = signed_lt(opa_sel, opb_sel) ||
						(opa_sel == opb_sel);
					default:         result = '0;
				endcase
			end
			isa_pkg::INTL_GRP: begin
				case (issue_i.inst.op.func)
					isa_pkg::AND:    result = opa_sel & opb_sel;
					isa_pkg::BIC:    result = opa_sel & ~opb_sel;
					isa_pkg::BIS:    result = opa_sel | opb_sel;
					isa_pkg::ORNOT:  result = opa_sel | ~opb_sel;
					isa_pkg::XOR:    result = opa_sel ^ opb_sel;
					isa_pkg::EQV:    result = opa_sel ^ ~opb_sel;
					default:         result = '0;
				endcase
			end
			isa_pkg::INTS_GRP: begin
				case (issue_i.inst.op.func)
					isa_pkg::SRL:    result = opa_sel >> opb_sel[5:0];
					isa_pkg::SLL:    result = opa_sel << opb_sel[5:0];
					isa_pkg::SRA:    result = $unsigned($signed(opa_sel) >>> opb_sel[5:0]);
					default:         result = '0;
				endcase
			end
			isa_pkg::LDA_INST: result = opa_sel + opb_sel;	// Base plus displacement
			default:           result = '0;
		endcase
	end

	// Recovery and mask clearing on the packet entering the stage
	assign enter_hit  = recov_i.recovery && |(issue_i.br_mask & recov_i.tag_fix);
	assign enter_mask = recov_i.pred_correct ? (issue_i.br_mask & ~recov_i.tag_fix) :
		issue_i.br_mask;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue_i.valid;	// Never stalls, credits guarantee room
		end
	end

	always_ff @(posedge clk) begin
		squashed_q <= enter_hit;
		result_q   <= result;
		dest_tag_q <= issue_i.dest_tag;
		rob_idx_q  <= issue_i.rob_idx;
		br_mask_q  <= enter_mask;
	end

	/* The held packet moves to the result queue at the next edge, so a
	 * branch resolving now is applied on the way out of the stage. */
	assign held_hit = recov_i.recovery && |(br_mask_q & recov_i.tag_fix);

	always_comb begin
		exec_o.valid    = valid_q;
		exec_o.squashed = squashed_q | held_hit;
		exec_o.result   = result_q;
		exec_o.dest_tag = dest_tag_q;
		exec_o.rob_idx  = rob_idx_q;
		exec_o.br_mask  = recov_i.pred_correct ? (br_mask_q & ~recov_i.tag_fix) : br_mask_q;
	end

endmodule

`default_nettype wire

/* hdl/fu_result_queue.sv */
/*
 * Result FIFO behind one functional unit. Holds results in issue order,
 * requests the CDB for a live head, drops squashed heads on its own and
 * returns one issue credit per popped entry.
 */
`timescale 1ns/1ns
`default_nettype none

module fu_result_queue #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::exec_pkt_s exec_i,
	input  core_pkg::br_recov_s recov_i,
	output logic                req_o,
	input  logic                grant_i,
	output core_pkg::exec_pkt_s head_o,
	output logic                credit_o
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	logic [QUEUE_DEPTH-1:0]         vld_q;
	logic [QUEUE_DEPTH-1:0]         sq_q;
	logic [core_pkg::BR_MASK_W-1:0] mask_q [QUEUE_DEPTH];
	logic [core_pkg::XLEN-1:0]      result_q [QUEUE_DEPTH];
	logic [core_pkg::PRF_IDX_W-1:0] dest_q [QUEUE_DEPTH];
	logic [core_pkg::ROB_IDX_W:0]   rob_q [QUEUE_DEPTH];
	logic [PTR_W-1:0]               rd_ptr;
	logic [PTR_W-1:0]               wr_ptr;
	logic                           credit_q;
	logic                           head_hit;
	logic                           head_sq;
	logic                           pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// A recovery this cycle already blocks the head from the bus
	assign head_hit = recov_i.recovery && |(mask_q[rd_ptr] & recov_i.tag_fix);
	assign head_sq  = sq_q[rd_ptr] | head_hit;

	assign req_o    = vld_q[rd_ptr] & ~head_sq;
	assign pop      = vld_q[rd_ptr] & (grant_i | head_sq);	// Squashed heads need no grant
	assign credit_o = credit_q;

	always_comb begin
		head_o.valid    = vld_q[rd_ptr];
		head_o.squashed = head_sq;
		head_o.result   = result_q[rd_ptr];
		head_o.dest_tag = dest_q[rd_ptr];
		head_o.rob_idx  = rob_q[rd_ptr];
		head_o.br_mask  = recov_i.pred_correct ? (mask_q[rd_ptr] & ~recov_i.tag_fix) :
			mask_q[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q    <= '0;
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			credit_q <= 1'b0;
		end else begin
			credit_q <= pop;
			if (pop) begin
				vld_q[rd_ptr] <= 1'b0;
				rd_ptr        <= ptr_inc(rd_ptr);
			end
			if (exec_i.valid) begin
				vld_q[wr_ptr] <= 1'b1;	// Every packet is accepted
				wr_ptr        <= ptr_inc(wr_ptr);
			end
		end
	end

	// Stored entries follow branch resolution in place
	always_ff @(posedge clk) begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (recov_i.recovery && |(mask_q[i] & recov_i.tag_fix)) begin
				sq_q[i] <= 1'b1;
			end
			if (recov_i.pred_correct) begin
				mask_q[i] <= mask_q[i] & ~recov_i.tag_fix;
			end
		end
		if (exec_i.valid) begin
			sq_q[wr_ptr]     <= exec_i.squashed;	// Already updated by the ALU
			mask_q[wr_ptr]   <= exec_i.br_mask;
			result_q[wr_ptr] <= exec_i.result;
			dest_q[wr_ptr]   <= exec_i.dest_tag;
			rob_q[wr_ptr]    <= exec_i.rob_idx;
		end
	end

endmodule

`default_nettype wire

/* hdl/cdb_arbiter.sv */
/*
 * Round-robin arbiter for the common data bus. Grants at most one
 * requester per cycle, searching from the one after the last winner.
 */
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter #(
	parameter int NUM_FU = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [NUM_FU-1:0] req_i,
	output logic [NUM_FU-1:0] grant_o
);

	localparam int IDX_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

	logic [IDX_W-1:0] last_q;	// Last granted requester
	logic [IDX_W-1:0] win_idx;

	always_comb begin
		int cand;
		grant_o = '0;
		win_idx = last_q;
		for (int k = 1; k <= NUM_FU; k++) begin
			cand = (int'(last_q) + k) % NUM_FU;
			if ((grant_o == '0) && req_i[cand]) begin
				grant_o[cand] = 1'b1;
				win_idx       = IDX_W'(cand);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			last_q <= IDX_W'(NUM_FU - 1);	// Requester 0 first after reset
		end else if (|grant_o) begin
			last_q <= win_idx;
		end
	end

endmodule

`default_nettype wire

/* hdl/exec_cluster.sv */
/*
 * Integer execution cluster top level. Two ALUs each feed a result queue,
 * and the queues share one common data bus through a round-robin arbiter.
 * Each ALU returns its issue credits on credit0_o and credit1_o.
 */
`timescale 1ns/1ns
`default_nettype none

module exec_cluster #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  core_pkg::issue_pkt_s issue0_i,
	input  core_pkg::issue_pkt_s issue1_i,
	input  core_pkg::br_recov_s  recov_i,
	output logic                 credit0_o,
	output logic                 credit1_o,
	output core_pkg::cdb_pkt_s   cdb_o
);

	localparam int NUM_FU = 2;

	core_pkg::issue_pkt_s issue [NUM_FU];
	core_pkg::exec_pkt_s  alu_out [NUM_FU];
	core_pkg::exec_pkt_s  head [NUM_FU];
	logic [NUM_FU-1:0]    req;
	logic [NUM_FU-1:0]    grant;
	logic [NUM_FU-1:0]    credit;

	assign issue[0]  = issue0_i;
	assign issue[1]  = issue1_i;
	assign credit0_o = credit[0];
	assign credit1_o = credit[1];

	for (genvar g = 0; g < NUM_FU; g++) begin : g_fu
		fu_alu u_alu (
			.clk     (clk),
			.rst     (rst),
			.issue_i (issue[g]),
			.recov_i (recov_i),
			.exec_o  (alu_out[g])
		);

		fu_result_queue #(
			.QUEUE_DEPTH (QUEUE_DEPTH)
		) u_queue (
			.clk      (clk),
			.rst      (rst),
			.exec_i   (alu_out[g]),
			.recov_i  (recov_i),
			.req_o    (req[g]),
			.grant_i  (grant[g]),
			.head_o   (head[g]),
			.credit_o (credit[g])
		);
	end

	cdb_arbiter #(
		.NUM_FU (NUM_FU)
	) u_arb (
		.clk     (clk),
		.rst     (rst),
		.req_i   (req),
		.grant_o (grant)
	);

	// Grant is one-hot, so the granted head drives the bus
	always_comb begin
		cdb_o = '0;
		for (int i = 0; i < NUM_FU; i++) begin
			if (grant[i]) begin
				cdb_o.valid    = 1'b1;
				cdb_o.result   = head[i].result;
				cdb_o.dest_tag = head[i].dest_tag;
				cdb_o.rob_idx  = head[i].rob_idx;
			end
		end
	end

endmodule

`default_nettype wire

/* test/exec_cluster_checker.sv */
/*
 * Concurrent assertions bound into the CDB arbiter and every result queue.
 * Checks grant legality, round-robin rotation, credit pulses and reset state.
 */
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_checker #(
	parameter int W = 1
) (
	input logic         clk,
	input logic         rst,
	input logic [W-1:0] req_i,
	input logic [W-1:0] grant_i,
	input logic [W-1:0] head_vld_i,
	input logic [W-1:0] credit_i
);

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant_i))
		else $error("more than one grant in a cycle");
	a_grant_req: assert property (@(posedge clk) disable iff (rst) (grant_i & ~req_i) == '0)
		else $error("grant to an idle requester");
	a_grant_head: assert property (@(posedge clk) disable iff (rst)
		(grant_i & ~head_vld_i) == '0)
		else $error("grant while the head is empty");

	// A pop is a valid head that is granted or not requesting, i.e. squashed
	a_credit_pop: assert property (@(posedge clk) disable iff (rst)
		(credit_i & ~$past(head_vld_i & (grant_i | ~req_i))) == '0)
		else $error("credit pulse without a pop");

	a_rotate: assert property (@(posedge clk) disable iff (rst)
		((W > 1) && (&req_i) && (|$past(grant_i))) |-> (grant_i != $past(grant_i)))
		else $error("same requester granted twice under contention");

	a_reset: assert property (@(posedge clk) rst |=> (grant_i == '0) && (credit_i == '0))
		else $error("grant or credit active right after reset");

endmodule

bind cdb_arbiter exec_cluster_checker #(.W(NUM_FU)) u_chk (
	.clk(clk), .rst(rst), .req_i(req_i), .grant_i(grant_o),
	.head_vld_i(req_i), .credit_i({NUM_FU{1'b0}})
);

bind fu_result_queue exec_cluster_checker #(.W(1)) u_chk (
	.clk(clk), .rst(rst), .req_i(req_o), .grant_i(grant_i),
	.head_vld_i(head_o.valid), .credit_i(credit_o)
);

`default_nettype wire

/* test/exec_cluster_tb.sv */
/*
 * Testbench for the integer execution cluster. Issues a table of ALU
 * operations to both units under credit flow control, drives branch
 * recovery together with selected rows and checks each CDB beat by rob_idx.
 */
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_tb;

	localparam int          QD       = 2;
	localparam logic [1:0]  EV_NONE  = 2'd0;
	localparam logic [1:0]  EV_PRED  = 2'd1;	// Correct prediction on tag_fix
	localparam logic [1:0]  EV_RECOV = 2'd2;	// Mispredict on tag_fix
	localparam logic [63:0] ONES     = '1;
	localparam logic [63:0] MSB      = 64'h8000_0000_0000_0000;

	typedef struct packed {
		logic                 unit;
		isa_pkg::alpha_inst_u inst;
		logic [63:0]          opa;
		logic [63:0]          opb;
		logic [5:0]           dest_tag;
		logic [5:0]           rob_idx;
		logic [3:0]           br_mask;
		logic [63:0]          exp_res;
		logic                 exp_sq;	// Must never reach the CDB
		logic [1:0]           ev;	// Branch resolution driven with the row
		logic [3:0]           tag_fix;
	} row_s;

	logic                 clk;
	logic                 rst;
	core_pkg::issue_pkt_s issue0;
	core_pkg::issue_pkt_s issue1;
	core_pkg::br_recov_s  recov;
	logic                 credit0;
	logic                 credit1;
	core_pkg::cdb_pkt_s   cdb;

	row_s rows[$];
	int   ord0[$];	// Live rob indices per unit, issue order
	int   ord1[$];
	int   credits[2];
	int   n_live;
	int   n_beats;
	logic table_ready;

	exec_cluster #(.QUEUE_DEPTH(QD)) dut0 (
		.clk       (clk),
		.rst       (rst),
		.issue0_i  (issue0),
		.issue1_i  (issue1),
		.recov_i   (recov),
		.credit0_o (credit0),
		.credit1_o (credit1),
		.cdb_o     (cdb)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic isa_pkg::alpha_inst_u op_word(input logic [5:0] grp, input logic [6:0] func);
		isa_pkg::alpha_inst_u w;
		w = '0;
		w.op.opcode = grp;
		w.op.func   = func;
		return w;
	endfunction

	function automatic isa_pkg::alpha_inst_u lit_word(input logic [5:0] grp,
		input logic [6:0] func, input logic [7:0] lit);
		isa_pkg::alpha_inst_u w;
		w = op_word(grp, func);
		w.op.is_lit = 1'b1;
		{w.op.rb, w.op.sbz} = lit;	// 8-bit literal field
		return w;
	endfunction

	function automatic isa_pkg::alpha_inst_u mem_word(input logic [15:0] disp);
		isa_pkg::alpha_inst_u w;
		w = '0;
		w.mem.opcode = isa_pkg::LDA_INST;
		w.mem.disp   = disp;
		return w;
	endfunction

	// Two rows share an issue cycle only on different units and with no branch event
	function automatic logic can_pair(input row_s a, input row_s b);
		return (a.unit != b.unit) && (a.ev == EV_NONE) && (b.ev == EV_NONE);
	endfunction

	task automatic add_br(input int unit, input isa_pkg::alpha_inst_u inst,
		input logic [63:0] opa, input logic [63:0] opb, input logic [3:0] mask,
		input logic [63:0] exp, input logic sq, input logic [1:0] ev, input logic [3:0] tag);
		row_s r;
		r.unit     = 1'(unit);
		r.inst     = inst;
		r.opa      = opa;
		r.opb      = opb;
		r.rob_idx  = 6'(rows.size());
		r.dest_tag = 6'(63 - rows.size());
		r.br_mask  = mask;
		r.exp_res  = exp;
		r.exp_sq   = sq;
		r.ev       = ev;
		r.tag_fix  = tag;
		rows.push_back(r);
		if (!sq) n_live++;
	endtask

	task automatic add_op(input int unit, input isa_pkg::alpha_inst_u inst,
		input logic [63:0] opa, input logic [63:0] opb, input logic [63:0] exp);
		add_br(unit, inst, opa, opb, 4'h0, exp, 1'b0, EV_NONE, 4'h0);
	endtask

	// Advance to the drive point of the next cycle with all inputs idle
	task automatic next_slot();
		@(posedge clk);
		#1;
		issue0 = '0;
		issue1 = '0;
		recov  = '0;
	endtask

	task automatic drive_row(input row_s r);
		core_pkg::issue_pkt_s p;
		p          = '0;
		p.valid    = 1'b1;
		p.opa      = r.opa;
		p.opb      = r.opb;
		p.inst     = r.inst;
		p.dest_tag = r.dest_tag;
		p.rob_idx  = r.rob_idx;
		p.br_mask  = r.br_mask;
		recov.recovery     = (r.ev == EV_RECOV);
		recov.pred_correct = (r.ev == EV_PRED);
		recov.tag_fix      = r.tag_fix;
		credits[r.unit]--;
		if (r.unit) issue1 = p;
		else issue0 = p;
		if (!r.exp_sq && r.unit) ord1.push_back(int'(r.rob_idx));
		if (!r.exp_sq && !r.unit) ord0.push_back(int'(r.rob_idx));
	endtask

	// Credit tracking and CDB scoreboard
	always @(posedge clk) begin
		int idx;
		int want;
		if (!rst) begin
			if (credit0) credits[0]++;
			if (credit1) credits[1]++;
			check_eq(credits[0] <= QD && credits[1] <= QD, 1, "credit count above queue depth");
			if (cdb.valid) begin
				idx  = -1;
				want = -1;
				foreach (rows[i]) if (rows[i].rob_idx == cdb.rob_idx) idx = i;
				check_eq(idx >= 0, 1, "CDB rob_idx not in the table");
				check_eq(64'(rows[idx].exp_sq), 64'd0, "squashed row on the CDB");
				if (rows[idx].unit && ord1.size() > 0) want = ord1.pop_front();
				if (!rows[idx].unit && ord0.size() > 0) want = ord0.pop_front();
				check_eq(64'(want), 64'(idx), "rob_idx out of issue order");
				check_eq(cdb.result, rows[idx].exp_res, "CDB result");
				check_eq(64'(cdb.dest_tag), 64'(rows[idx].dest_tag), "CDB dest_tag");
				n_beats++;
			end
		end
	end

	initial begin
		wait (table_ready);
		repeat (rows.size() * 20 + 10) @(posedge clk);
		$display("Watchdog timeout: results or credits did not all come back");
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int gap;
		int ri;
		void'($urandom(42));
		rst         = 1'b1;
		issue0      = '0;
		issue1      = '0;
		recov       = '0;
		credits[0]  = QD;
		credits[1]  = QD;
		n_live      = 0;
		n_beats     = 0;
		table_ready = 1'b0;

		add_op(0, op_word(isa_pkg::INTA_GRP, isa_pkg::ADDQ), ONES, 64'd1, 64'd0);	// Wraps
		add_op(1, op_word(isa_pkg::INTA_GRP, isa_pkg::SUBQ), 64'd5, 64'd7, ONES - 64'd1);
		add_op(0, op_word(isa_pkg::INTA_GRP, isa_pkg::CMPEQ), 64'd9, 64'd9, 64'd1);
		add_op(1, op_word(isa_pkg::INTA_GRP, isa_pkg::CMPULT), 64'd1, ONES, 64'd1);
		add_op(0, op_word(isa_pkg::INTA_GRP, isa_pkg::CMPULE), 64'd8, 64'd8, 64'd1);
		add_op(1, op_word(isa_pkg::INTA_GRP, isa_pkg::CMPLT), ONES, 64'd1, 64'd1);
		add_op(0, op_word(isa_pkg::INTA_GRP, isa_pkg::CMPLE), 64'd2, ONES - 64'd1, 64'd0);
		add_op(1, lit_word(isa_pkg::INTA_GRP, isa_pkg::ADDQ, 8'hFF), 64'd100, ONES, 64'h163);
		add_op(0, op_word(isa_pkg::INTL_GRP, isa_pkg::AND), 64'hF0F0, 64'hFF00, 64'hF000);
		add_op(1, op_word(isa_pkg::INTL_GRP, isa_pkg::BIC), 64'hF0F0, 64'hFF00, 64'h00F0);
		add_op(0, op_word(isa_pkg::INTL_GRP, isa_pkg::BIS), 64'hF0F0, 64'hFF00, 64'hFFF0);
		add_op(1, op_word(isa_pkg::INTL_GRP, isa_pkg::ORNOT), 64'd0, ONES << 32, ONES >> 32);
		add_op(0, op_word(isa_pkg::INTL_GRP, isa_pkg::XOR), 64'hF0F0, 64'hFF00, 64'h0FF0);
		add_op(1, op_word(isa_pkg::INTL_GRP, isa_pkg::EQV), 64'h0F, 64'hF0, ONES << 8);
		add_op(0, op_word(isa_pkg::INTS_GRP, isa_pkg::SRL), MSB, 64'd4, 64'h0800 << 48);
		add_op(1, lit_word(isa_pkg::INTS_GRP, isa_pkg::SLL, 8'd63), 64'd1, 64'd0, MSB);
		add_op(0, op_word(isa_pkg::INTS_GRP, isa_pkg::SRA), MSB, 64'd4, 64'hF800 << 48);
		add_op(1, mem_word(16'h0010), 64'd0, 64'h1000, 64'h1010);
		add_op(0, mem_word(16'hFFF0), 64'd0, 64'h1000, 64'h0FF0);	// Negative displacement
		add_br(1, op_word(isa_pkg::INTA_GRP, isa_pkg::ADDQ), 64'd1, 64'd1,
			4'b0001, 64'd2, 1'b1, EV_RECOV, 4'b0001);
		add_br(0, op_word(isa_pkg::INTL_GRP, isa_pkg::BIS), 64'd1, 64'd2,
			4'b0010, 64'd3, 1'b1, EV_RECOV, 4'b0010);
		add_br(1, op_word(isa_pkg::INTL_GRP, isa_pkg::AND), 64'd3, 64'd6,
			4'b0100, 64'd2, 1'b0, EV_NONE, 4'h0);
		add_br(0, op_word(isa_pkg::INTL_GRP, isa_pkg::XOR), 64'd3, 64'd6,
			4'b0100, 64'd5, 1'b0, EV_NONE, 4'h0);
		add_br(1, op_word(isa_pkg::INTA_GRP, isa_pkg::ADDQ), 64'd2, 64'd2,
			4'b0100, 64'd4, 1'b0, EV_PRED, 4'b0100);	// Resolves bit 2 as correct
		add_br(0, op_word(isa_pkg::INTA_GRP, isa_pkg::SUBQ), 64'd10, 64'd3,
			4'b0100, 64'd7, 1'b1, EV_RECOV, 4'b0100);	// Earlier bit 2 rows survive
		table_ready = 1'b1;

		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		ri  = 0;
		while (ri < rows.size()) begin
			next_slot();
			gap = 0;
			// Branch rows back to back so resolution finds earlier rows in flight
			if (rows[ri].br_mask == 4'h0 && rows[ri].ev == EV_NONE) begin
				gap = $urandom_range(2, 0);
			end
			repeat (gap) next_slot();
			while (credits[rows[ri].unit] == 0) next_slot();
			drive_row(rows[ri]);
			ri++;
			// Other unit in the same cycle so both queues contend for the CDB
			if (ri < rows.size() && can_pair(rows[ri - 1], rows[ri]) &&
				credits[rows[ri].unit] > 0) begin
				drive_row(rows[ri]);
				ri++;
			end
		end
		next_slot();

		// All live results seen and every credit back
		while (n_beats < n_live || credits[0] != QD || credits[1] != QD) @(posedge clk);
		repeat (4) @(posedge clk);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* exec_cluster.f */
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/fu_alu.sv
hdl/fu_result_queue.sv
hdl/cdb_arbiter.sv
hdl/exec_cluster.sv
test/exec_cluster_checker.sv
test/exec_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the execution cluster testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f exec_cluster.f \
	--top-module exec_cluster_tb -o exec_cluster_sim || exit 1
out="$(./obj_dir/exec_cluster_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q '^SIMULATION PASSED$' && exit 0 || exit 1
